/* hw/id_pkg.sv */
// ----------------------------------------
// Decode stage types
// Vector types for instructions, PCs and register fields
// ----------------------------------------

`include "id_stage_macros.svh"

package id_pkg;

  // ----------------------------------------
  // Instruction words
  // ----------------------------------------

  // Full 32-bit instruction, also the expanded form of a compressed one
  typedef logic [`ILEN-1:0] instr_t;

  // Compressed half-word as fetched
  typedef logic [15:0] cinstr_t;

  // ----------------------------------------
  // Data path values
  // ----------------------------------------

  // PC or sign-extended immediate
  typedef logic [`XLEN-1:0] xlen_t;

  // Architectural register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // ----------------------------------------
  // Decode results
  // ----------------------------------------

  // Operation class, holds one of the OP_* codes
  //   ALU     OP and OP-IMM
  //   BRANCH  conditional branches
  //   JUMP    JAL and JALR
  //   LOAD    loads of any width
  //   STORE   stores of any width
  //   LUI     upper immediate
  //   AUIPC   PC-relative upper immediate
  typedef logic [2:0] op_class_t;

endpackage

/* hw/id_stage.sv */
// ----------------------------------------
// Instruction decode stage
// Two expand/decode lanes feeding the decode-to-issue register
// ----------------------------------------

`include "id_stage_macros.svh"

module id_stage (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           flush_i,
  input  id_pkg::instr_t    [`NR_ISSUE_PORTS-1:0]        fetch_instr_i,
  input  id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        fetch_pc_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        fetch_valid_i,
  output logic              [`NR_ISSUE_PORTS-1:0]        fetch_ready_o,
  input  logic              [`NR_ISSUE_PORTS-1:0]        issue_ack_i,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_valid_o,
  output id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        issue_pc_o,
  output id_pkg::instr_t    [`NR_ISSUE_PORTS-1:0]        orig_instr_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_compressed_o,
  output id_pkg::op_class_t [`NR_ISSUE_PORTS-1:0]        issue_op_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rd_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rs1_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rs2_o,
  output id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        issue_imm_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_illegal_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_ctrl_flow_o
);

  import id_pkg::*;

  instr_t    [`NR_ISSUE_PORTS-1:0] exp_instr;
  logic      [`NR_ISSUE_PORTS-1:0] exp_compressed;
  logic      [`NR_ISSUE_PORTS-1:0] exp_illegal;
  op_class_t [`NR_ISSUE_PORTS-1:0] dec_op;
  reg_addr_t [`NR_ISSUE_PORTS-1:0] dec_rd, dec_rs1, dec_rs2;
  xlen_t     [`NR_ISSUE_PORTS-1:0] dec_imm;
  logic      [`NR_ISSUE_PORTS-1:0] dec_illegal;
  logic      [`NR_ISSUE_PORTS-1:0] dec_ctrl_flow;

  // ----------------------------------------
  // Lanes: expand, then decode
  // ----------------------------------------
  for (genvar i = 0; i < `NR_ISSUE_PORTS; i++) begin : gen_lane
    rvc_expander rvc_expander_i (
      .instr_i        (fetch_instr_i[i]),
      .instr_o        (exp_instr[i]),
      .is_compressed_o(exp_compressed[i]),
      .illegal_o      (exp_illegal[i])
    );

    instr_decoder instr_decoder_i (
      .instr_i    (exp_instr[i]),
      .illegal_i  (exp_illegal[i]),
      .op_o       (dec_op[i]),
      .rd_o       (dec_rd[i]),
      .rs1_o      (dec_rs1[i]),
      .rs2_o      (dec_rs2[i]),
      .imm_o      (dec_imm[i]),
      .illegal_o  (dec_illegal[i]),
      .ctrl_flow_o(dec_ctrl_flow[i])
    );
  end

  // Original fetch word travels with the entry
  issue_register issue_register_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .issue_ack_i       (issue_ack_i),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_ready_o     (fetch_ready_o),
    .pc_i              (fetch_pc_i),
    .orig_instr_i      (fetch_instr_i),
    .is_compressed_i   (exp_compressed),
    .op_i              (dec_op),
    .rd_i              (dec_rd),
    .rs1_i             (dec_rs1),
    .rs2_i             (dec_rs2),
    .imm_i             (dec_imm),
    .illegal_i         (dec_illegal),
    .ctrl_flow_i       (dec_ctrl_flow),
    .issue_valid_o     (issue_valid_o),
    .issue_pc_o        (issue_pc_o),
    .orig_instr_o      (orig_instr_o),
    .issue_compressed_o(issue_compressed_o),
    .issue_op_o        (issue_op_o),
    .issue_rd_o        (issue_rd_o),
    .issue_rs1_o       (issue_rs1_o),
    .issue_rs2_o       (issue_rs2_o),
    .issue_imm_o       (issue_imm_o),
    .issue_illegal_o   (issue_illegal_o),
    .issue_ctrl_flow_o (issue_ctrl_flow_o)
  );

endmodule

/* hw/id_stage_macros.svh */
// ----------------------------------------
// Decode stage widths and encodings
// Shared widths, lane count and the operation-class codes
// ----------------------------------------

`ifndef ID_STAGE_MACROS_SVH
`define ID_STAGE_MACROS_SVH

// Data path and PC width
`define XLEN 32
// Full instruction width
`define ILEN 32
// Fetch and issue lanes
`define NR_ISSUE_PORTS 2

// Operation classes seen by the issue stage
`define OP_ALU    3'd0
`define OP_BRANCH 3'd1
`define OP_JUMP   3'd2
`define OP_LOAD   3'd3
`define OP_STORE  3'd4
`define OP_LUI    3'd5
`define OP_AUIPC  3'd6

`endif

/* hw/instr_decoder.sv */
// ----------------------------------------
// Instruction decoder
// Splits one RV32I instruction into issue-entry fields
// ----------------------------------------

`include "id_stage_macros.svh"

module instr_decoder (
  input  id_pkg::instr_t    instr_i,
  input  logic              illegal_i,
  output id_pkg::op_class_t op_o,
  output id_pkg::reg_addr_t rd_o,
  output id_pkg::reg_addr_t rs1_o,
  output id_pkg::reg_addr_t rs2_o,
  output id_pkg::xlen_t     imm_o,
  output logic              illegal_o,
  output logic              ctrl_flow_o
);

  import id_pkg::*;

  // RV32I base opcodes
  localparam logic [6:0] OpcLui    = 7'b0110111;
  localparam logic [6:0] OpcAuipc  = 7'b0010111;
  localparam logic [6:0] OpcJal    = 7'b1101111;
  localparam logic [6:0] OpcJalr   = 7'b1100111;
  localparam logic [6:0] OpcBranch = 7'b1100011;
  localparam logic [6:0] OpcLoad   = 7'b0000011;
  localparam logic [6:0] OpcStore  = 7'b0100011;
  localparam logic [6:0] OpcOpImm  = 7'b0010011;
  localparam logic [6:0] OpcOp     = 7'b0110011;

  reg_addr_t rd_f, rs1_f, rs2_f;
  xlen_t     imm_i_f, imm_s_f, imm_b_f, imm_u_f, imm_j_f;
  logic      known;

  assign rd_f  = instr_i[11:7];
  assign rs1_f = instr_i[19:15];
  assign rs2_f = instr_i[24:20];

  // ----------------------------------------
  // Immediate formats, all sign-extended
  // ----------------------------------------
  assign imm_i_f = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_f = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_f = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_f = {instr_i[31:12], 12'b0};
  assign imm_j_f = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    op_o        = `OP_ALU;
    rd_o        = '0;
    rs1_o       = '0;
    rs2_o       = '0;
    imm_o       = '0;
    ctrl_flow_o = 1'b0;
    known       = 1'b1;

    case (instr_i[6:0])
      OpcLui: begin
        op_o  = `OP_LUI;
        rd_o  = rd_f;
        imm_o = imm_u_f;
      end
      OpcAuipc: begin
        op_o  = `OP_AUIPC;
        rd_o  = rd_f;
        imm_o = imm_u_f;
      end
      OpcJal: begin
        op_o        = `OP_JUMP;
        rd_o        = rd_f;
        imm_o       = imm_j_f;
        ctrl_flow_o = 1'b1;
      end
      OpcJalr: begin
        op_o        = `OP_JUMP;
        rd_o        = rd_f;
        rs1_o       = rs1_f;
        imm_o       = imm_i_f;
        ctrl_flow_o = 1'b1;
      end
      OpcBranch: begin
        op_o        = `OP_BRANCH;
        rs1_o       = rs1_f;
        rs2_o       = rs2_f;
        imm_o       = imm_b_f;
        ctrl_flow_o = 1'b1;
      end
      OpcLoad: begin
        op_o  = `OP_LOAD;
        rd_o  = rd_f;
        rs1_o = rs1_f;
        imm_o = imm_i_f;
      end
      OpcStore: begin
        op_o  = `OP_STORE;
        rs1_o = rs1_f;
        rs2_o = rs2_f;
        imm_o = imm_s_f;
      end
      OpcOpImm: begin
        rd_o  = rd_f;
        rs1_o = rs1_f;
        imm_o = imm_i_f;
      end
      OpcOp: begin
        rd_o  = rd_f;
        rs1_o = rs1_f;
        rs2_o = rs2_f;
      end
      default: known = 1'b0;
    endcase

    illegal_o = illegal_i | ~known;

    // An illegal entry carries only its flag
    if (illegal_o) begin
      op_o        = '0;
      rd_o        = '0;
      rs1_o       = '0;
      rs2_o       = '0;
      imm_o       = '0;
      ctrl_flow_o = 1'b0;
    end
  end

endmodule

/* hw/issue_register.sv */
// ----------------------------------------
// Decode-to-issue register
// Two entry slots, drained by ack, refilled from the fetch ports
// ----------------------------------------

`include "id_stage_macros.svh"

module issue_register (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           flush_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        issue_ack_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        fetch_valid_i,
  output logic              [`NR_ISSUE_PORTS-1:0]        fetch_ready_o,
  input  id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        pc_i,
  input  id_pkg::instr_t    [`NR_ISSUE_PORTS-1:0]        orig_instr_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        is_compressed_i,
  input  id_pkg::op_class_t [`NR_ISSUE_PORTS-1:0]        op_i,
  input  id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        rd_i,
  input  id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        rs1_i,
  input  id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        rs2_i,
  input  id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        imm_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        illegal_i,
  input  logic              [`NR_ISSUE_PORTS-1:0]        ctrl_flow_i,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_valid_o,
  output id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        issue_pc_o,
  output id_pkg::instr_t    [`NR_ISSUE_PORTS-1:0]        orig_instr_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_compressed_o,
  output id_pkg::op_class_t [`NR_ISSUE_PORTS-1:0]        issue_op_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rd_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rs1_o,
  output id_pkg::reg_addr_t [`NR_ISSUE_PORTS-1:0]        issue_rs2_o,
  output id_pkg::xlen_t     [`NR_ISSUE_PORTS-1:0]        issue_imm_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_illegal_o,
  output logic              [`NR_ISSUE_PORTS-1:0]        issue_ctrl_flow_o
);

  import id_pkg::*;

  typedef struct packed {
    xlen_t     pc;
    instr_t    orig_instr;
    logic      compressed;
    op_class_t op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;
    logic      illegal;
    logic      ctrl_flow;
  } entry_t;

  entry_t [`NR_ISSUE_PORTS-1:0] port_entry;
  entry_t [`NR_ISSUE_PORTS-1:0] slot_d, slot_q;
  logic   [`NR_ISSUE_PORTS-1:0] valid_d, valid_q;

  for (genvar i = 0; i < `NR_ISSUE_PORTS; i++) begin : gen_lane
    assign port_entry[i] = '{pc_i[i], orig_instr_i[i], is_compressed_i[i], op_i[i], rd_i[i],
                             rs1_i[i], rs2_i[i], imm_i[i], illegal_i[i], ctrl_flow_i[i]};

    assign issue_valid_o[i]      = valid_q[i];
    assign issue_pc_o[i]         = slot_q[i].pc;
    assign orig_instr_o[i]       = slot_q[i].orig_instr;
    assign issue_compressed_o[i] = slot_q[i].compressed;
    assign issue_op_o[i]         = slot_q[i].op;
    assign issue_rd_o[i]         = slot_q[i].rd;
    assign issue_rs1_o[i]        = slot_q[i].rs1;
    assign issue_rs2_o[i]        = slot_q[i].rs2;
    assign issue_imm_o[i]        = slot_q[i].imm;
    assign issue_illegal_o[i]    = slot_q[i].illegal;
    assign issue_ctrl_flow_o[i]  = slot_q[i].ctrl_flow;
  end

  // ----------------------------------------
  // Slot update: ack, shift, fill, flush
  // ----------------------------------------
  always_comb begin
    slot_d        = slot_q;
    valid_d       = valid_q & ~issue_ack_i;
    fetch_ready_o = '0;

    // Slot 0 holds the oldest entry, so it refills from slot 1 first
    if (!valid_d[0]) begin
      if (valid_d[1]) begin
        slot_d[0]  = slot_q[1];
        valid_d[0] = 1'b1;
        valid_d[1] = 1'b0;
      end else if (fetch_valid_i[0]) begin
        slot_d[0]        = port_entry[0];
        valid_d[0]       = 1'b1;
        fetch_ready_o[0] = 1'b1;
      end
    end

    if (!valid_d[1]) begin
      if (fetch_ready_o[0]) begin
        if (fetch_valid_i[1]) begin
          slot_d[1]        = port_entry[1];
          valid_d[1]       = 1'b1;
          fetch_ready_o[1] = 1'b1;
        end
      end else if (fetch_valid_i[0]) begin
        slot_d[1]        = port_entry[0];
        valid_d[1]       = 1'b1;
        fetch_ready_o[0] = 1'b1;
      end
    end

    if (flush_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    slot_q <= slot_d;
  end

endmodule

/* hw/rvc_expander.sv */
// ----------------------------------------
// RVC expander
// Expands the supported compressed instructions to their 32-bit form
// ----------------------------------------

module rvc_expander (
  input  id_pkg::instr_t instr_i,
  output id_pkg::instr_t instr_o,
  output logic           is_compressed_o,
  output logic           illegal_o
);

  import id_pkg::*;

  cinstr_t c;

  // Low half-word carries the compressed encoding
  assign c = instr_i[15:0];

  always_comb begin
    instr_o         = instr_i;
    is_compressed_o = 1'b0;
    illegal_o       = 1'b0;

    if (c[1:0] != 2'b11) begin
      is_compressed_o = 1'b1;
      // Unsupported encodings fall through zero-extended
      instr_o         = {16'b0, c};
      illegal_o       = 1'b1;

      case (c[1:0])
        // ----------------------------------------
        // Quadrant 0
        // ----------------------------------------
        2'b00: begin
          case (c[15:13])
            3'b010: begin
              // C.LW -> lw rd', uimm(rs1')
              instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                           3'b010, 2'b01, c[4:2], 7'b0000011};
              illegal_o = 1'b0;
            end
            3'b110: begin
              // C.SW -> sw rs2', uimm(rs1')
              instr_o   = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                           3'b010, c[11:10], c[6], 2'b00, 7'b0100011};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end

        // ----------------------------------------
        // Quadrant 1
        // ----------------------------------------
        2'b01: begin
          case (c[15:13])
            3'b000: begin
              // C.ADDI -> addi rd, rd, imm (C.NOP included)
              instr_o   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], 7'b0010011};
              illegal_o = 1'b0;
            end
            3'b010: begin
              // C.LI -> addi rd, x0, imm
              instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7], 7'b0010011};
              illegal_o = 1'b0;
            end
            3'b011: begin
              // C.LUI, rd=x2 would be C.ADDI16SP and a zero immediate is reserved
              if (c[11:7] != 5'd2 && {c[12], c[6:2]} != 6'b0) begin
                instr_o   = {{14{c[12]}}, c[12], c[6:2], c[11:7], 7'b0110111};
                illegal_o = 1'b0;
              end
            end
            3'b101: begin
              // C.J -> jal x0, offset
              instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, 5'b0, 7'b1101111};
              illegal_o = 1'b0;
            end
            3'b110, 3'b111: begin
              // C.BEQZ / C.BNEZ -> beq/bne rs1', x0, offset
              instr_o   = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7],
                           2'b00, c[13], c[11:10], c[4:3], c[12], 7'b1100011};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end

        // ----------------------------------------
        // Quadrant 2
        // ----------------------------------------
        2'b10: begin
          if (c[15:13] == 3'b100) begin
            if (c[6:2] != 5'b0) begin
              if (c[12]) begin
                // C.ADD -> add rd, rd, rs2
                instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0110011};
              end else begin
                // C.MV -> add rd, x0, rs2
                instr_o = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], 7'b0110011};
              end
              illegal_o = 1'b0;
            end else if (c[11:7] != 5'b0) begin
              // C.JALR links through x1, C.JR discards the link
              instr_o   = {12'b0, c[11:7], 3'b000, 4'b0, c[12], 7'b1100111};
              illegal_o = 1'b0;
            end
            // rs1=x0 is C.EBREAK or reserved, left illegal
          end
        end

        default: ;
      endcase
    end
  end

endmodule

/* id_stage.f */
+incdir+hw
hw/id_pkg.sv
hw/rvc_expander.sv
hw/instr_decoder.sv
hw/issue_register.sv
hw/id_stage.sv
sim/tb_clk_gen.sv
sim/tb_id_stage.sv

/* sim/tb_clk_gen.sv */
// ----------------------------------------
// Testbench clock and reset
// ----------------------------------------

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for 10 cycles
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* sim/tb_id_stage.sv */
// ----------------------------------------
// Decode stage testbench
// Directed tests against a spec-level model
// ----------------------------------------

`include "id_stage_macros.svh"

module tb_id_stage;

  import id_pkg::*;

  typedef struct packed {
    instr_t    instr;
    xlen_t     pc;
    logic      comp;
    op_class_t op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;
    logic      ill;
    logic      cf;
  } exp_t;

  logic clk_i, rst_ni, flush_i;
  instr_t    [1:0] fetch_instr_i;
  xlen_t     [1:0] fetch_pc_i;
  logic      [1:0] fetch_valid_i, fetch_ready_o, issue_ack_i, issue_valid_o;
  xlen_t     [1:0] issue_pc_o, issue_imm_o;
  instr_t    [1:0] orig_instr_o;
  logic      [1:0] issue_compressed_o, issue_illegal_o, issue_ctrl_flow_o;
  op_class_t [1:0] issue_op_o;
  reg_addr_t [1:0] issue_rd_o, issue_rs1_o, issue_rs2_o;

  int   errors;
  int   test_errors;
  int   tests_run;
  int   tests_failed;
  xlen_t next_pc;
  exp_t  sb_q[$];

  tb_clk_gen tb_clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  id_stage id_stage_i (.*);

  // Global limit on the run
  initial begin
    #400000;
    $display("Run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  task automatic at_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic fail_msg(string msg);
    $display("Failure at %0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic compare_slot(int s, exp_t e);
    check_val($sformatf("issue_valid_o[%0d]", s), 1, issue_valid_o[s]);
    check_val("issue_pc_o", e.pc, issue_pc_o[s]);
    check_val("orig_instr_o", e.instr, orig_instr_o[s]);
    check_val("issue_compressed_o", e.comp, issue_compressed_o[s]);
    check_val("issue_op_o", e.op, issue_op_o[s]);
    check_val("issue_rd_o", e.rd, issue_rd_o[s]);
    check_val("issue_rs1_o", e.rs1, issue_rs1_o[s]);
    check_val("issue_rs2_o", e.rs2, issue_rs2_o[s]);
    check_val("issue_imm_o", e.imm, issue_imm_o[s]);
    check_val("issue_illegal_o", e.ill, issue_illegal_o[s]);
    check_val("issue_ctrl_flow_o", e.cf, issue_ctrl_flow_o[s]);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, test_errors);
    end else begin
      $display("Test %s: ok", name);
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  // ----------------------------------------
  // Model: build an encoding and its expected decode
  // ----------------------------------------
  task automatic gen_instr(input int kind, output instr_t w, output exp_t e);
    logic [31:0] r;
    reg_addr_t   rd, rs1, rs2;
    logic [2:0]  rdp, rsp;
    logic [11:0] i12, cj;
    logic [19:0] u20;
    logic [20:0] jo;
    logic [12:0] bo;
    logic [5:0]  i6;
    logic [8:0]  cb;
    logic [6:0]  cu;
    cinstr_t     c;
    r   = $urandom;
    rd  = $urandom;
    rs1 = $urandom;
    rs2 = $urandom;
    rdp = $urandom;
    rsp = $urandom;
    i12 = r[11:0];
    u20 = r[31:12];
    jo  = {r[19:0], 1'b0};
    bo  = {r[11:0], 1'b0};
    i6  = r[5:0];
    cj  = {r[10:0], 1'b0};
    cb  = {r[7:0], 1'b0};
    cu  = {r[4:0], 2'b00};
    e   = '0;
    c   = '0;
    w   = '0;
    e.comp = (kind >= 9 && kind <= 21);
    case (kind)
      0: begin
        w     = {u20, rd, 7'b0110111};
        e.op  = `OP_LUI;
        e.rd  = rd;
        e.imm = {u20, 12'b0};
      end
      1: begin
        w     = {u20, rd, 7'b0010111};
        e.op  = `OP_AUIPC;
        e.rd  = rd;
        e.imm = {u20, 12'b0};
      end
      2: begin
        w     = {jo[20], jo[10:1], jo[11], jo[19:12], rd, 7'b1101111};
        e.op  = `OP_JUMP;
        e.rd  = rd;
        e.imm = {{11{jo[20]}}, jo};
        e.cf  = 1;
      end
      3: begin
        w     = {i12, rs1, 3'b000, rd, 7'b1100111};
        e.op  = `OP_JUMP;
        e.rd  = rd;
        e.rs1 = rs1;
        e.imm = {{20{i12[11]}}, i12};
        e.cf  = 1;
      end
      4: begin
        w     = {bo[12], bo[10:5], rs2, rs1, 3'b000, bo[4:1], bo[11], 7'b1100011};
        e.op  = `OP_BRANCH;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.imm = {{19{bo[12]}}, bo};
        e.cf  = 1;
      end
      5: begin
        w     = {i12, rs1, 3'b010, rd, 7'b0000011};
        e.op  = `OP_LOAD;
        e.rd  = rd;
        e.rs1 = rs1;
        e.imm = {{20{i12[11]}}, i12};
      end
      6: begin
        w     = {i12[11:5], rs2, rs1, 3'b010, i12[4:0], 7'b0100011};
        e.op  = `OP_STORE;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.imm = {{20{i12[11]}}, i12};
      end
      7: begin
        w     = {i12, rs1, 3'b000, rd, 7'b0010011};
        e.op  = `OP_ALU;
        e.rd  = rd;
        e.rs1 = rs1;
        e.imm = {{20{i12[11]}}, i12};
      end
      8: begin
        w     = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
        e.op  = `OP_ALU;
        e.rd  = rd;
        e.rs1 = rs1;
        e.rs2 = rs2;
      end
      9: begin
        c     = {3'b000, i6[5], rd, i6[4:0], 2'b01};
        e.op  = `OP_ALU;
        e.rd  = rd;
        e.rs1 = rd;
        e.imm = {{26{i6[5]}}, i6};
      end
      10: begin
        c     = {3'b010, i6[5], rd, i6[4:0], 2'b01};
        e.op  = `OP_ALU;
        e.rd  = rd;
        e.imm = {{26{i6[5]}}, i6};
      end
      11: begin
        if (rd == 5'd0 || rd == 5'd2) rd = 5'd3;
        if (i6 == 6'd0) i6 = 6'd1;
        c     = {3'b011, i6[5], rd, i6[4:0], 2'b01};
        e.op  = `OP_LUI;
        e.rd  = rd;
        e.imm = {{14{i6[5]}}, i6, 12'b0};
      end
      12, 13: begin
        if (rs2 == 5'd0) rs2 = 5'd1;
        c     = {3'b100, (kind == 13), rd, rs2, 2'b10};
        e.op  = `OP_ALU;
        e.rd  = rd;
        e.rs2 = rs2;
        e.rs1 = (kind == 13) ? rd : 5'd0;
      end
      14: begin
        c     = {3'b101, cj[11], cj[4], cj[9:8], cj[10], cj[6], cj[7], cj[3:1], cj[5], 2'b01};
        e.op  = `OP_JUMP;
        e.imm = {{20{cj[11]}}, cj};
        e.cf  = 1;
      end
      15, 16: begin
        if (rs1 == 5'd0) rs1 = 5'd1;
        c     = {3'b100, (kind == 16), rs1, 5'b0, 2'b10};
        e.op  = `OP_JUMP;
        e.rs1 = rs1;
        e.rd  = (kind == 16) ? 5'd1 : 5'd0;
        e.cf  = 1;
      end
      17, 18: begin
        c     = {2'b11, (kind == 18), cb[8], cb[4:3], rsp, cb[7:6], cb[2:1], cb[5], 2'b01};
        e.op  = `OP_BRANCH;
        e.rs1 = {2'b01, rsp};
        e.imm = {{23{cb[8]}}, cb};
        e.cf  = 1;
      end
      19: begin
        c     = {3'b010, cu[5:3], rsp, cu[2], cu[6], rdp, 2'b00};
        e.op  = `OP_LOAD;
        e.rd  = {2'b01, rdp};
        e.rs1 = {2'b01, rsp};
        e.imm = {25'b0, cu};
      end
      20: begin
        c     = {3'b110, cu[5:3], rsp, cu[2], cu[6], rdp, 2'b00};
        e.op  = `OP_STORE;
        e.rs2 = {2'b01, rdp};
        e.rs1 = {2'b01, rsp};
        e.imm = {25'b0, cu};
      end
      21: begin
        // ADDI4SPN, C.LUI with zero immediate, C.EBREAK
        case (r[31:30])
          2'd0: c = 16'h0000;
          2'd1: c = {3'b011, 1'b0, rd, 5'b0, 2'b01};
          default: c = 16'h9002;
        endcase
        e.ill = 1;
      end
      default: begin
        w     = {r[24:0], 7'b1111111};
        e.ill = 1;
      end
    endcase
    if (e.comp) w = {r[31:16] ^ 16'h5a5a, c};
    e.instr = w;
    e.pc    = next_pc;
    next_pc = next_pc + (e.comp ? 32'd2 : 32'd4);
  endtask

  task automatic drive_idle();
    fetch_valid_i = '0;
    issue_ack_i   = '0;
    flush_i       = 1'b0;
  endtask

  // One entry through port 0, taken as soon as it shows
  task automatic issue_one(int kind);
    instr_t w;
    exp_t   e;
    int     t;
    gen_instr(kind, w, e);
    at_drive_point();
    fetch_instr_i[0] = w;
    fetch_pc_i[0]    = e.pc;
    fetch_valid_i[0] = 1'b1;
    #1;
    t = 0;
    while (!fetch_ready_o[0]) begin
      if (t == 20) begin
        fail_msg("port 0 never became ready");
        break;
      end
      @(posedge clk_i);
      #2;
      t++;
    end
    at_drive_point();
    fetch_valid_i  = '0;
    issue_ack_i[0] = 1'b1;
    #1;
    compare_slot(0, e);
    check_val("issue_valid_o[1]", 0, issue_valid_o[1]);
    at_drive_point();
    issue_ack_i = '0;
    #1;
    check_val("issue_valid_o", 0, issue_valid_o);
  endtask

  task automatic test_reset();
    at_drive_point();
    fetch_valid_i = 2'b01;
    #1;
    check_val("issue_valid_o", 0, issue_valid_o);
    check_val("fetch_ready_o", 2'b01, fetch_ready_o);
    fetch_valid_i = 2'b00;
    #1;
    check_val("fetch_ready_o", 0, fetch_ready_o);
    finish_test("reset");
  endtask

  task automatic test_decode32();
    for (int k = 0; k <= 8; k++) issue_one(k);
    finish_test("decode32");
  endtask

  task automatic test_compressed();
    for (int n = 0; n < 4; n++) begin
      for (int k = 9; k <= 22; k++) issue_one(k);
    end
    finish_test("compressed");
  endtask

  // Fill both slots from one fetch pair
  task automatic fill_pair(output exp_t e0, output exp_t e1);
    instr_t w0, w1;
    gen_instr($urandom_range(0, 20), w0, e0);
    gen_instr($urandom_range(0, 20), w1, e1);
    at_drive_point();
    fetch_instr_i = {w1, w0};
    fetch_pc_i    = {e1.pc, e0.pc};
    fetch_valid_i = 2'b11;
    #1;
    check_val("fetch_ready_o", 2'b11, fetch_ready_o);
  endtask

  task automatic test_dual();
    exp_t e0, e1;
    fill_pair(e0, e1);
    at_drive_point();
    #1;
    compare_slot(0, e0);
    compare_slot(1, e1);
    check_val("fetch_ready_o", 0, fetch_ready_o);
    fetch_valid_i = '0;
    issue_ack_i   = 2'b01;
    at_drive_point();
    issue_ack_i = 2'b01;
    #1;
    compare_slot(0, e1);
    check_val("issue_valid_o[1]", 0, issue_valid_o[1]);
    at_drive_point();
    issue_ack_i = '0;
    #1;
    check_val("issue_valid_o", 0, issue_valid_o);
    finish_test("dual");
  endtask

  task automatic test_random();
    instr_t     w0, w1;
    exp_t       e0, e1, s;
    int         t;
    int         n_free;
    logic [1:0] exp_ready;
    for (int cyc = 0; cyc < 300; cyc++) begin
      gen_instr($urandom_range(0, 22), w0, e0);
      gen_instr($urandom_range(0, 22), w1, e1);
      at_drive_point();
      fetch_instr_i  = {w1, w0};
      fetch_pc_i     = {e1.pc, e0.pc};
      fetch_valid_i  = $urandom_range(0, 3);
      issue_ack_i[0] = issue_valid_o[0] & $urandom_range(0, 1);
      issue_ack_i[1] = issue_ack_i[0] & issue_valid_o[1] & $urandom_range(0, 1);
      #1;
      for (int sl = 0; sl < 2; sl++) begin
        if (issue_ack_i[sl]) begin
          if (sb_q.size() == 0) begin
            fail_msg("issue entry acknowledged with nothing outstanding");
          end else begin
            s = sb_q.pop_front();
            compare_slot(sl, s);
          end
        end
      end
      // Ready only for slots left free after this cycle's acks
      n_free       = 2 - sb_q.size();
      exp_ready[0] = fetch_valid_i[0] && (n_free >= 1);
      exp_ready[1] = exp_ready[0] && fetch_valid_i[1] && (n_free == 2);
      check_val("fetch_ready_o", exp_ready, fetch_ready_o);
      // Port 0 is older than port 1
      if (fetch_ready_o[0] && fetch_valid_i[0]) sb_q.push_back(e0);
      if (fetch_ready_o[1] && fetch_valid_i[1]) sb_q.push_back(e1);
      // Pairs that were not taken are not reused, so the PC runs on
    end
    at_drive_point();
    fetch_valid_i = '0;
    issue_ack_i   = '0;
    t = 0;
    while (sb_q.size() != 0) begin
      if (t == 10) begin
        fail_msg("entries lost in the issue register");
        break;
      end
      at_drive_point();
      issue_ack_i = issue_valid_o & 2'b01;
      #1;
      if (issue_ack_i[0]) begin
        s = sb_q.pop_front();
        compare_slot(0, s);
      end
      t++;
    end
    at_drive_point();
    issue_ack_i = '0;
    #1;
    check_val("issue_valid_o", 0, issue_valid_o);
    finish_test("random");
  endtask

  task automatic test_flush();
    exp_t e0, e1;
    fill_pair(e0, e1);
    at_drive_point();
    // Acks free both slots, so the pending fetch pair would refill them
    flush_i     = 1'b1;
    issue_ack_i = 2'b11;
    #1;
    check_val("issue_valid_o", 2'b11, issue_valid_o);
    at_drive_point();
    drive_idle();
    #1;
    check_val("issue_valid_o", 0, issue_valid_o);
    finish_test("flush");
  endtask

  initial begin
    int t;
    errors        = 0;
    test_errors   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    next_pc       = 32'h8000_0000;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    drive_idle();
    void'($urandom(32'h26b7));
    t = 0;
    while (rst_ni !== 1'b1 && t < 50) begin
      @(posedge clk_i);
      t++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Reset was never released");
      $display("** FAIL **");
    end else begin
      test_reset();
      test_decode32();
      test_compressed();
      test_dual();
      test_random();
      test_flush();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

endmodule
